// ==== logic/tau_defines.svh ====
/*
 * Tensor engine sizes shared by the accumulation path
 */
`ifndef TAU_DEFINES_SVH
`define TAU_DEFINES_SVH

// Loop shape
`define TAU_DIM       2
`define TAU_WORK_BW   8
`define TAU_VSIZE     4
`define TAU_MAX_WARP  16
`define TAU_N_CFG     4

// Scratch memory
`define TAU_MEM_AW    8
`define TAU_MEM_DEPTH (1 << `TAU_MEM_AW)
`define TAU_DATA_BW   16

`endif

// ==== logic/tau_cfg_pkg.sv ====
/*
 * Loop-side types: host command, warp record and derived widths
 */
`include "tau_defines.svh"

package tau_cfg_pkg;

	// Derived widths
	localparam int CV_BW     = $clog2(`TAU_VSIZE);
	localparam int LO_ORD_BW = $clog2(CV_BW + 1);
	localparam int UP_ORD_BW = LO_ORD_BW + 1;
	localparam int WID_BW    = $clog2(`TAU_MAX_WARP);
	localparam int NCFG_BW   = $clog2(`TAU_N_CFG + 1);

	typedef logic [`TAU_DIM-1:0][`TAU_WORK_BW-1:0] nd_ofs_t;
	typedef logic [`TAU_DIM-1:0][UP_ORD_BW-1:0]    nd_up_ord_t;
	typedef logic [`TAU_DIM-1:0][LO_ORD_BW-1:0]    nd_lo_ord_t;
	typedef logic [`TAU_DIM-1:0]                   nd_flag_t;
	typedef logic [NCFG_BW-1:0]                    cfg_id_t;
	typedef logic [WID_BW-1:0]                     warp_id_t;

	typedef struct packed {
		nd_ofs_t    bofs;
		nd_ofs_t    aofs;
		nd_flag_t   a_reset_flag;
		nd_flag_t   a_add_flag;
		logic       islast;
		cfg_id_t    id_beg;
		cfg_id_t    id_end;
		cfg_id_t    id_ret;
		nd_ofs_t    blocal_last;
		nd_up_ord_t bsub_up_order;
		nd_lo_ord_t bsub_lo_order;
	} index_cmd_t;

	typedef struct packed {
		nd_flag_t a_reset_flag;
		nd_flag_t a_add_flag;
		nd_flag_t bu_reset_flag;
		nd_flag_t bu_add_flag;
		nd_flag_t bl_reset_flag;
		nd_flag_t bl_add_flag;
		cfg_id_t  id;
		warp_id_t warpid;
		nd_ofs_t  bofs;
		nd_ofs_t  aofs;
		logic     retire;
		logic     islast;
	} warp_rec_t;

endpackage

// ==== logic/tau_bus_pkg.sv ====
/*
 * Memory-side types: scratch requests, requesters and write records
 */
`include "tau_defines.svh"

package tau_bus_pkg;

	localparam int N_REQ = 3;

	typedef logic [`TAU_MEM_AW-1:0]  mem_addr_t;
	typedef logic [`TAU_DATA_BW-1:0] mem_data_t;

	typedef struct packed {
		logic      we;
		mem_addr_t addr;
		mem_data_t wdata;
	} scratch_req_t;

	typedef struct packed {
		mem_data_t rdata;
	} scratch_rsp_t;

	typedef enum logic [1:0] {LOAD, FETCH, ACCUM} requester_e;

	typedef enum logic [1:0] {IDLE, READ_A, WRITE_A, EMIT} acc_state_e;

	typedef struct packed {
		mem_addr_t            addr;
		mem_data_t            value;
		tau_cfg_pkg::cfg_id_t  id;
		tau_cfg_pkg::warp_id_t warpid;
		logic                 retire;
		logic                 islast;
	} acc_wr_t;

	// Word address of an offset pair, dim 0 plus 16 rows of dim 1
	function automatic mem_addr_t ofs_to_addr(input tau_cfg_pkg::nd_ofs_t ofs);
		return ofs[0] + {ofs[1][3:0], 4'b0000};
	endfunction

endpackage

// ==== logic/nd_offset_counter.sv ====
/*
 * Two-dimensional offset counter with carry chain and step flags
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module nd_offset_counter (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_load,
	input  logic                    i_step_en,
	input  tau_cfg_pkg::nd_ofs_t    i_end,
	input  tau_cfg_pkg::nd_up_ord_t i_order,
	input  logic                    i_carry,
	output tau_cfg_pkg::nd_ofs_t    o_cur,
	output tau_cfg_pkg::nd_flag_t   o_reset_flag,
	output tau_cfg_pkg::nd_flag_t   o_add_flag,
	output logic                    o_done
);

logic [`TAU_DIM:0]    carry;
tau_cfg_pkg::nd_ofs_t step;

// Dimension 0 takes the carry in, a wrapped dimension passes it on
always_comb begin
	carry[0] = i_carry;
	for (int i = 0; i < `TAU_DIM; i++) begin
		o_reset_flag[i] = carry[i] && (o_cur[i] == i_end[i]);
		o_add_flag[i]   = carry[i] && (o_cur[i] != i_end[i]);
		carry[i+1]      = o_reset_flag[i];
		step[i]         = `TAU_WORK_BW'(1) << i_order[i];
	end
end

assign o_done = carry[`TAU_DIM];

always_ff @(posedge i_clk) begin
	if (i_rst || i_load) begin
		o_cur <= '0;
	end else if (i_step_en) begin
		for (int i = 0; i < `TAU_DIM; i++) begin
			if (o_reset_flag[i]) begin
				o_cur[i] <= '0;
			end else if (o_add_flag[i]) begin
				o_cur[i] <= o_cur[i] + step[i];
			end
		end
	end
end

endmodule

// ==== logic/awl_index_stage.sv ====
/*
 * Index stage: expands one host command into a stream of warp records,
 * ids innermost, offsets from a lower and an upper counter
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module awl_index_stage (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_cmd_rdy,
	output logic                   o_cmd_ack,
	input  tau_cfg_pkg::index_cmd_t i_cmd,
	output logic                   o_warp_rdy,
	input  logic                   i_warp_ack,
	output tau_cfg_pkg::warp_rec_t  o_warp
);

// ==================================================
// Internal
// ==================================================
tau_cfg_pkg::index_cmd_t cmd_r;
tau_cfg_pkg::cfg_id_t    id_r;
tau_cfg_pkg::cfg_id_t    id_nxt;
tau_cfg_pkg::warp_id_t   warpid_r;
logic                    a_first_r;
tau_cfg_pkg::nd_flag_t   bu_reset_r;
tau_cfg_pkg::nd_flag_t   bu_add_r;
tau_cfg_pkg::nd_flag_t   bl_reset_r;
tau_cfg_pkg::nd_flag_t   bl_add_r;
tau_cfg_pkg::nd_ofs_t    lower_end;
tau_cfg_pkg::nd_ofs_t    lo_cur;
tau_cfg_pkg::nd_ofs_t    up_cur;
tau_cfg_pkg::nd_flag_t   lo_reset;
tau_cfg_pkg::nd_flag_t   lo_add;
tau_cfg_pkg::nd_flag_t   up_reset;
tau_cfg_pkg::nd_flag_t   up_add;
logic                    lo_done;
logic                    up_done;
logic                    is_lastid;
logic                    last_rec;
logic                    adv;

// ==================================================
// Combinational
// ==================================================
// A new command only enters once the previous stream has drained
assign o_cmd_ack = i_cmd_rdy && !o_warp_rdy;
assign adv       = i_warp_ack && is_lastid;
assign last_rec  = is_lastid && up_done;

always_comb begin
	id_nxt    = id_r + 1'b1;
	is_lastid = id_nxt == cmd_r.id_end;
	// Lower end is all ones below the lower order
	for (int i = 0; i < `TAU_DIM; i++) begin
		lower_end[i] = {{(`TAU_WORK_BW - tau_cfg_pkg::CV_BW){1'b0}},
			~({tau_cfg_pkg::CV_BW{1'b1}} << cmd_r.bsub_lo_order[i])};
	end
end

always_comb begin
	o_warp.a_reset_flag  = a_first_r ? cmd_r.a_reset_flag : '0;
	o_warp.a_add_flag    = a_first_r ? cmd_r.a_add_flag : '0;
	o_warp.bu_reset_flag = bu_reset_r;
	o_warp.bu_add_flag   = bu_add_r;
	o_warp.bl_reset_flag = bl_reset_r;
	o_warp.bl_add_flag   = bl_add_r;
	o_warp.id            = id_r;
	o_warp.warpid        = warpid_r;
	for (int i = 0; i < `TAU_DIM; i++) begin
		o_warp.bofs[i] = cmd_r.bofs[i] + (lo_cur[i] | up_cur[i]);
	end
	o_warp.aofs   = cmd_r.aofs;
	o_warp.retire = up_done && (id_r < cmd_r.id_ret);
	o_warp.islast = last_rec && cmd_r.islast;
end

// ==================================================
// Counters
// ==================================================
nd_offset_counter u_lower (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_load       (o_cmd_ack),
	.i_step_en    (adv),
	.i_end        (lower_end),
	.i_order      ('0),
	.i_carry      (1'b1),
	.o_cur        (lo_cur),
	.o_reset_flag (lo_reset),
	.o_add_flag   (lo_add),
	.o_done       (lo_done)
);

nd_offset_counter u_upper (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_load       (o_cmd_ack),
	.i_step_en    (adv),
	.i_end        (cmd_r.blocal_last),
	.i_order      (cmd_r.bsub_up_order),
	.i_carry      (lo_done),
	.o_cur        (up_cur),
	.o_reset_flag (up_reset),
	.o_add_flag   (up_add),
	.o_done       (up_done)
);

// ==================================================
// Sequential
// ==================================================
always_ff @(posedge i_clk) begin
	if (o_cmd_ack) begin
		cmd_r <= i_cmd;
	end
end

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		o_warp_rdy <= 1'b0;
		id_r       <= '0;
		warpid_r   <= '0;
		a_first_r  <= 1'b0;
		bu_reset_r <= '0;
		bu_add_r   <= '0;
		bl_reset_r <= '0;
		bl_add_r   <= '0;
	end else if (o_cmd_ack) begin
		o_warp_rdy <= 1'b1;
		id_r       <= i_cmd.id_beg;
		warpid_r   <= '0;
		a_first_r  <= 1'b1;
		bu_reset_r <= '1;
		bu_add_r   <= '0;
		bl_reset_r <= '1;
		bl_add_r   <= '0;
	end else if (i_warp_ack) begin
		a_first_r <= 1'b0;
		if (last_rec) begin
			o_warp_rdy <= 1'b0;
		end
		if (is_lastid) begin
			// Id wrap moves the offsets to the next warp
			id_r       <= cmd_r.id_beg;
			warpid_r   <= warpid_r + 1'b1;
			bu_reset_r <= up_reset;
			bu_add_r   <= up_add;
			bl_reset_r <= lo_reset;
			bl_add_r   <= lo_add;
		end else begin
			id_r <= id_nxt;
		end
	end
end

// A taken command always yields a record, and no second command overlaps it
a_cmd_hold: assert property (@(posedge i_clk) disable iff (i_rst)
	o_cmd_ack |=> o_warp_rdy && !o_cmd_ack);

endmodule

// ==== logic/warp_operand_fetch.sv ====
/*
 * Operand fetch: reads the B word of each warp from the shared scratch
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module warp_operand_fetch (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_warp_rdy,
	output logic                      o_warp_ack,
	input  tau_cfg_pkg::warp_rec_t    i_warp,
	output logic                      o_req,
	output tau_bus_pkg::scratch_req_t o_req_pkt,
	input  logic                      i_gnt,
	input  tau_bus_pkg::scratch_rsp_t i_rsp,
	output logic                      o_opnd_rdy,
	input  logic                      i_opnd_ack,
	output tau_cfg_pkg::warp_rec_t    o_opnd_rec,
	output logic [`TAU_DATA_BW-1:0]   o_opnd_data
);

logic rd_pend_r;

// One warp at a time, held until the next stage takes it
assign o_warp_ack = i_warp_rdy && !o_req && !rd_pend_r && !o_opnd_rdy;

always_comb begin
	o_req_pkt.we    = 1'b0;
	o_req_pkt.addr  = tau_bus_pkg::ofs_to_addr(o_opnd_rec.bofs);
	o_req_pkt.wdata = '0;
end

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		o_req      <= 1'b0;
		rd_pend_r  <= 1'b0;
		o_opnd_rdy <= 1'b0;
	end else begin
		if (o_warp_ack) begin
			o_req <= 1'b1;
		end else if (i_gnt) begin
			o_req <= 1'b0;
		end
		rd_pend_r <= i_gnt;
		if (rd_pend_r) begin
			o_opnd_rdy <= 1'b1;
		end else if (i_opnd_ack) begin
			o_opnd_rdy <= 1'b0;
		end
	end
end

// Record and read word
always_ff @(posedge i_clk) begin
	if (o_warp_ack) begin
		o_opnd_rec <= i_warp;
	end
	if (rd_pend_r) begin
		o_opnd_data <= i_rsp.rdata;
	end
end

a_gnt_on_req: assert property (@(posedge i_clk) disable iff (i_rst) i_gnt |-> o_req);

endmodule

// ==== logic/accum_update.sv ====
/*
 * Accumulator update: read-modify-write of the A word per warp,
 * then one write record to the host
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module accum_update (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_opnd_rdy,
	output logic                      o_opnd_ack,
	input  tau_cfg_pkg::warp_rec_t    i_opnd_rec,
	input  logic [`TAU_DATA_BW-1:0]   i_opnd_data,
	output logic                      o_req,
	output tau_bus_pkg::scratch_req_t o_req_pkt,
	input  logic                      i_gnt,
	input  tau_bus_pkg::scratch_rsp_t i_rsp,
	output logic                      o_wr_rdy,
	input  logic                      i_wr_ack,
	output tau_bus_pkg::acc_wr_t      o_wr
);

tau_bus_pkg::acc_state_e state_r;
logic                    rd_pend_r;
logic                    a_reset_r;
logic [`TAU_DATA_BW-1:0] b_data_r;
logic [`TAU_DATA_BW-1:0] acc_val;

assign o_opnd_ack = i_opnd_rdy && (state_r == tau_bus_pkg::IDLE);
assign o_wr_rdy   = state_r == tau_bus_pkg::EMIT;
assign o_req      = (state_r == tau_bus_pkg::READ_A && !rd_pend_r) ||
	(state_r == tau_bus_pkg::WRITE_A);

// Reset flag drops the old A word, otherwise add with 16-bit wrap
assign acc_val = a_reset_r ? b_data_r : i_rsp.rdata + b_data_r;

always_comb begin
	o_req_pkt.we    = state_r == tau_bus_pkg::WRITE_A;
	o_req_pkt.addr  = o_wr.addr;
	o_req_pkt.wdata = o_wr.value;
end

// ==================================================
// FSM
// ==================================================
always_ff @(posedge i_clk) begin
	if (i_rst) begin
		state_r   <= tau_bus_pkg::IDLE;
		rd_pend_r <= 1'b0;
	end else begin
		unique case (state_r)
			tau_bus_pkg::IDLE: begin
				if (o_opnd_ack) begin
					state_r <= tau_bus_pkg::READ_A;
				end
			end
			tau_bus_pkg::READ_A: begin
				if (rd_pend_r) begin
					rd_pend_r <= 1'b0;
					state_r   <= tau_bus_pkg::WRITE_A;
				end else if (i_gnt) begin
					rd_pend_r <= 1'b1;
				end
			end
			tau_bus_pkg::WRITE_A: begin
				if (i_gnt) begin
					state_r <= tau_bus_pkg::EMIT;
				end
			end
			tau_bus_pkg::EMIT: begin
				if (i_wr_ack) begin
					state_r <= tau_bus_pkg::IDLE;
				end
			end
		endcase
	end
end

// Record fields from the operand, value once the old word is back
always_ff @(posedge i_clk) begin
	if (o_opnd_ack) begin
		o_wr.addr   <= tau_bus_pkg::ofs_to_addr(i_opnd_rec.aofs);
		o_wr.id     <= i_opnd_rec.id;
		o_wr.warpid <= i_opnd_rec.warpid;
		o_wr.retire <= i_opnd_rec.retire;
		o_wr.islast <= i_opnd_rec.islast;
		a_reset_r   <= |i_opnd_rec.a_reset_flag;
		b_data_r    <= i_opnd_data;
	end
	if (state_r == tau_bus_pkg::READ_A && rd_pend_r) begin
		o_wr.value <= acc_val;
	end
end

a_emit_hold: assert property (@(posedge i_clk) disable iff (i_rst)
	o_wr_rdy && !i_wr_ack |=> state_r == tau_bus_pkg::EMIT && $stable(o_wr));

endmodule

// ==== logic/shared_scratch.sv ====
/*
 * Shared scratch: round-robin arbiter over load, fetch and accumulator
 * in front of a single-port memory array
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module shared_scratch (
	input  logic                                                i_clk,
	input  logic                                                i_rst,
	input  logic [tau_bus_pkg::N_REQ-1:0]                       i_req,
	input  tau_bus_pkg::scratch_req_t [tau_bus_pkg::N_REQ-1:0]  i_req_pkt,
	output logic [tau_bus_pkg::N_REQ-1:0]                       o_gnt,
	output tau_bus_pkg::scratch_rsp_t                           o_rsp
);

tau_bus_pkg::requester_e   ptr_r;
tau_bus_pkg::requester_e   win;
tau_bus_pkg::requester_e   win_nxt;
logic [1:0]                cand;
logic                      found;
tau_bus_pkg::scratch_req_t sel_pkt;
logic [`TAU_DATA_BW-1:0]   mem [`TAU_MEM_DEPTH];
logic [`TAU_DATA_BW-1:0]   rd_data_r;

// Search starts at the pointer and takes the first pending requester
always_comb begin
	found = 1'b0;
	win   = ptr_r;
	cand  = '0;
	for (int k = 0; k < tau_bus_pkg::N_REQ; k++) begin
		cand = 2'((int'(ptr_r) + k) % tau_bus_pkg::N_REQ);
		if (!found && i_req[cand]) begin
			found = 1'b1;
			win   = tau_bus_pkg::requester_e'(cand);
		end
	end
	o_gnt      = '0;
	o_gnt[win] = found;
	sel_pkt    = i_req_pkt[win];
	win_nxt    = (win == tau_bus_pkg::ACCUM) ? tau_bus_pkg::LOAD :
		tau_bus_pkg::requester_e'(win + 2'd1);
end

always_ff @(posedge i_clk) begin
	if (i_rst) begin
		ptr_r <= tau_bus_pkg::LOAD;
	end else if (found) begin
		ptr_r <= win_nxt;
	end
end

always_ff @(posedge i_clk) begin
	if (found) begin
		if (sel_pkt.we) begin
			mem[sel_pkt.addr] <= sel_pkt.wdata;
		end else begin
			rd_data_r <= mem[sel_pkt.addr];
		end
	end
end

assign o_rsp.rdata = rd_data_r;

a_gnt_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
	$onehot0(o_gnt) && ((o_gnt & ~i_req) == '0));

endmodule

// ==== logic/accum_looper_top.sv ====
/*
 * Accumulation path top: index stage, operand fetch, accumulator
 * update and shared scratch
 */
`timescale 1ns/1ps
`include "tau_defines.svh"

module accum_looper_top (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_cmd_rdy,
	output logic                      o_cmd_ack,
	input  tau_cfg_pkg::index_cmd_t   i_cmd,
	input  logic                      i_load_req,
	input  tau_bus_pkg::scratch_req_t i_load_pkt,
	output logic                      o_load_gnt,
	output logic                      o_wr_rdy,
	input  logic                      i_wr_ack,
	output tau_bus_pkg::acc_wr_t      o_wr
);

logic                                               warp_rdy;
logic                                               warp_ack;
tau_cfg_pkg::warp_rec_t                             warp;
logic                                               opnd_rdy;
logic                                               opnd_ack;
tau_cfg_pkg::warp_rec_t                             opnd_rec;
logic [`TAU_DATA_BW-1:0]                            opnd_data;
logic [tau_bus_pkg::N_REQ-1:0]                      req;
tau_bus_pkg::scratch_req_t [tau_bus_pkg::N_REQ-1:0] req_pkt;
logic [tau_bus_pkg::N_REQ-1:0]                      gnt;
tau_bus_pkg::scratch_rsp_t                          rsp;

// Host preload shares the arbiter
assign req[tau_bus_pkg::LOAD]     = i_load_req;
assign req_pkt[tau_bus_pkg::LOAD] = i_load_pkt;
assign o_load_gnt                 = gnt[tau_bus_pkg::LOAD];

awl_index_stage u_index (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_cmd_rdy(i_cmd_rdy), .o_cmd_ack(o_cmd_ack), .i_cmd(i_cmd),
	.o_warp_rdy(warp_rdy), .i_warp_ack(warp_ack), .o_warp(warp)
);

warp_operand_fetch u_fetch (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_warp_rdy(warp_rdy), .o_warp_ack(warp_ack), .i_warp(warp),
	.o_req(req[tau_bus_pkg::FETCH]), .o_req_pkt(req_pkt[tau_bus_pkg::FETCH]),
	.i_gnt(gnt[tau_bus_pkg::FETCH]), .i_rsp(rsp),
	.o_opnd_rdy(opnd_rdy), .i_opnd_ack(opnd_ack),
	.o_opnd_rec(opnd_rec), .o_opnd_data(opnd_data)
);

accum_update u_accum (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_opnd_rdy(opnd_rdy), .o_opnd_ack(opnd_ack),
	.i_opnd_rec(opnd_rec), .i_opnd_data(opnd_data),
	.o_req(req[tau_bus_pkg::ACCUM]), .o_req_pkt(req_pkt[tau_bus_pkg::ACCUM]),
	.i_gnt(gnt[tau_bus_pkg::ACCUM]), .i_rsp(rsp),
	.o_wr_rdy(o_wr_rdy), .i_wr_ack(i_wr_ack), .o_wr(o_wr)
);

shared_scratch u_scratch (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_req(req), .i_req_pkt(req_pkt), .o_gnt(gnt), .o_rsp(rsp)
);

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
 * Free-running testbench clock, 20 ns period
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk
);

localparam int HALF_NS = 10;

initial begin
	o_clk = 1'b0;
	forever begin
		#HALF_NS o_clk = ~o_clk;
	end
end

endmodule

// ==== sim/tb_accum_looper.sv ====
/*
 * Accumulation path testbench: preload, commands and expected write
 * records come from the golden file, host ack on wr is randomly delayed
 */
`timescale 1ns/1ps

module tb_accum_looper;

localparam int GOLD_WORDS     = 512;
localparam int CYCLES_PER_CMD = 400;

logic                      clk;
logic                      i_rst;
logic                      i_cmd_rdy;
logic                      o_cmd_ack;
tau_cfg_pkg::index_cmd_t   i_cmd;
logic                      i_load_req;
tau_bus_pkg::scratch_req_t i_load_pkt;
logic                      o_load_gnt;
logic                      o_wr_rdy;
logic                      i_wr_ack;
tau_bus_pkg::acc_wr_t      o_wr;

logic [15:0]               golden [GOLD_WORDS];
tau_cfg_pkg::index_cmd_t   cmd_q [$];
tau_bus_pkg::acc_wr_t      exp_q [$];
integer                    seed;
int                        n_checks;
int                        n_errors;
int                        n_tests;
int                        limit_cycles;

tb_clock_gen u_clk (.o_clk(clk));

accum_looper_top i_accum_looper_top (
	.i_clk(clk), .i_rst(i_rst),
	.i_cmd_rdy(i_cmd_rdy), .o_cmd_ack(o_cmd_ack), .i_cmd(i_cmd),
	.i_load_req(i_load_req), .i_load_pkt(i_load_pkt), .o_load_gnt(o_load_gnt),
	.o_wr_rdy(o_wr_rdy), .i_wr_ack(i_wr_ack), .o_wr(o_wr)
);

// ==================================================
// Golden file records
// ==================================================
// Words per record kind, zero ends the file
function automatic int rec_len(input logic [15:0] kind);
	case (kind)
		16'h1: return 3;
		16'h2: return 17;
		16'h3: return 7;
		16'h4: return 2;
		default: return 0;
	endcase
endfunction

function automatic tau_cfg_pkg::index_cmd_t build_cmd(input int p);
	tau_cfg_pkg::index_cmd_t c;
	c                  = '0;
	c.bofs[0]          = golden[p+1][7:0];
	c.bofs[1]          = golden[p+2][7:0];
	c.aofs[0]          = golden[p+3][7:0];
	c.aofs[1]          = golden[p+4][7:0];
	c.a_reset_flag     = golden[p+5][1:0];
	c.a_add_flag       = golden[p+6][1:0];
	c.islast           = golden[p+7][0];
	c.id_beg           = golden[p+8][2:0];
	c.id_end           = golden[p+9][2:0];
	c.id_ret           = golden[p+10][2:0];
	c.blocal_last[0]   = golden[p+11][7:0];
	c.blocal_last[1]   = golden[p+12][7:0];
	c.bsub_up_order[0] = golden[p+13][2:0];
	c.bsub_up_order[1] = golden[p+14][2:0];
	c.bsub_lo_order[0] = golden[p+15][1:0];
	c.bsub_lo_order[1] = golden[p+16][1:0];
	return c;
endfunction

function automatic tau_bus_pkg::acc_wr_t build_exp(input int p);
	tau_bus_pkg::acc_wr_t e;
	e.addr   = golden[p+1][7:0];
	e.value  = golden[p+2];
	e.id     = golden[p+3][2:0];
	e.warpid = golden[p+4][3:0];
	e.retire = golden[p+5][0];
	e.islast = golden[p+6][0];
	return e;
endfunction

// ==================================================
// Host side tasks
// ==================================================
task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
	n_checks++;
	if (got !== want) begin
		n_errors++;
		$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, want);
	end
endtask

// All host tasks start and end 2 ns after a rising edge
task automatic preload_word(input logic [7:0] addr, input logic [15:0] data);
	logic granted;
	i_load_pkt.we    = 1'b1;
	i_load_pkt.addr  = addr;
	i_load_pkt.wdata = data;
	i_load_req       = 1'b1;
	granted          = 1'b0;
	while (!granted) begin
		#1;
		granted = o_load_gnt;
		@(posedge clk);
		#2;
	end
	i_load_req = 1'b0;
endtask

task automatic drive_cmds();
	logic taken;
	while (cmd_q.size() > 0) begin
		i_cmd     = cmd_q.pop_front();
		i_cmd_rdy = 1'b1;
		taken     = 1'b0;
		while (!taken) begin
			#1;
			taken = o_cmd_ack;
			@(posedge clk);
			#2;
		end
		i_cmd_rdy = 1'b0;
	end
endtask

task automatic collect_wr(input int n_rec);
	tau_bus_pkg::acc_wr_t e;
	int                   delay;
	for (int k = 0; k < n_rec; k++) begin
		e = exp_q.pop_front();
		while (!o_wr_rdy) begin
			@(posedge clk);
			#2;
		end
		delay = $random(seed) & 3;
		repeat (delay) begin
			@(posedge clk);
			#2;
		end
		check_value(32'(o_wr_rdy), 32'd1, $sformatf("record %0d ready held", k));
		check_value(32'(o_wr.addr), 32'(e.addr), $sformatf("record %0d address", k));
		check_value(32'(o_wr.value), 32'(e.value), $sformatf("record %0d value", k));
		check_value(32'(o_wr.id), 32'(e.id), $sformatf("record %0d id", k));
		check_value(32'(o_wr.warpid), 32'(e.warpid), $sformatf("record %0d warp id", k));
		check_value(32'(o_wr.retire), 32'(e.retire), $sformatf("record %0d retire", k));
		check_value(32'(o_wr.islast), 32'(e.islast), $sformatf("record %0d islast", k));
		i_wr_ack = 1'b1;
		@(posedge clk);
		#2;
		i_wr_ack = 1'b0;
	end
endtask

task automatic run_test(input int test_no);
	int n_rec;
	int err_before;
	n_rec      = exp_q.size();
	err_before = n_errors;
	fork
		drive_cmds();
		collect_wr(n_rec);
	join
	// Quiet period, a duplicated record would show up here
	repeat (8) begin
		@(posedge clk);
		#2;
	end
	check_value(32'(o_wr_rdy), 32'd0, "write ready after the last record");
	n_tests++;
	$display("Test %0d: %0d records, %0d mismatches", test_no, n_rec, n_errors - err_before);
endtask

// ==================================================
// Main sequence and watchdog
// ==================================================
initial begin : main
	int p;
	int n_cmd;
	int n_load;
	int n_run;
	i_rst      = 1'b1;
	i_cmd_rdy  = 1'b0;
	i_cmd      = '0;
	i_load_req = 1'b0;
	i_load_pkt = '0;
	i_wr_ack   = 1'b0;
	seed       = 32'h671f_bc54;
	n_checks   = 0;
	n_errors   = 0;
	n_tests    = 0;
	n_cmd      = 0;
	n_load     = 0;
	n_run      = 0;
	$readmemh("sim/accum_golden.txt", golden);

	// First pass sizes the watchdog
	p = 0;
	while (p < GOLD_WORDS && rec_len(golden[p]) > 0) begin
		if (golden[p] == 16'h1) n_load++;
		if (golden[p] == 16'h2) n_cmd++;
		if (golden[p] == 16'h4) n_run++;
		p += rec_len(golden[p]);
	end
	if (p >= GOLD_WORDS || golden[p] != 16'h0) begin
		n_errors++;
		$display("Golden file has an unknown record kind at word %0d", p);
	end
	if (n_cmd == 0) begin
		n_errors++;
		$display("Golden file holds no commands");
	end
	limit_cycles = 20 + n_load * 8 + n_run * 10 + n_cmd * CYCLES_PER_CMD;

	repeat (10) @(posedge clk);
	#2;
	i_rst = 1'b0;

	p = 0;
	while (p < GOLD_WORDS && rec_len(golden[p]) > 0) begin
		case (golden[p])
			16'h1: preload_word(golden[p+1][7:0], golden[p+2]);
			16'h2: cmd_q.push_back(build_cmd(p));
			16'h3: exp_q.push_back(build_exp(p));
			default: run_test(int'(golden[p+1]));
		endcase
		p += rec_len(golden[p]);
	end

	$display("Tests: %0d, checks: %0d, mismatches: %0d", n_tests, n_checks, n_errors);
	if (n_errors == 0) begin
		$display("No errors");
	end else begin
		$display("Errors found");
	end
	$finish;
end

initial begin : watchdog
	wait (limit_cycles > 0);
	repeat (limit_cycles) @(posedge clk);
	$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
	$display("Errors found");
	$finish;
end

endmodule

// ==== sim/accum_golden.txt ====
// Kinds: 1 preload (addr data), 2 command (bofs0 bofs1 aofs0 aofs1 arst aadd islast
// beg end ret bll0 bll1 uo0 uo1 lo0 lo1), 3 expected wr (addr value id warpid retire islast),
// 4 run test (number), 0 end of file
// Test 1, single warp with A reset
1 12 1234
2 02 01 00 08 3 0 1 0 1 1 00 00 0 0 0 0
3 80 1234 0 0 1 1
4 1
// Test 2, ids 1 to 3, sum wraps at 16 bits
1 04 6000
2 04 00 01 08 3 0 1 1 4 2 00 00 0 0 0 0
3 81 6000 1 0 1 0
3 81 c000 2 0 0 0
3 81 2000 3 0 0 1
4 2
// Test 3, lower order 1 and upper last 4 step 2, not the last command
1 20 0011
1 21 0022
1 22 0033
1 23 0044
1 24 0055
1 25 0066
2 00 02 02 08 3 0 0 0 1 1 04 00 1 0 1 0
3 82 0011 0 0 0 0
3 82 0033 0 1 0 0
3 82 0066 0 2 0 0
3 82 00aa 0 3 0 0
3 82 00ff 0 4 0 0
3 82 0165 0 5 1 0
4 3
// Test 4, two ids per warp, retire below id 1
1 08 0100
1 09 0200
2 08 00 03 08 3 0 1 0 2 1 00 00 0 0 1 0
3 83 0100 0 0 0 0
3 83 0200 1 0 0 0
3 83 0400 0 1 1 0
3 83 0600 1 1 0 1
4 4
// Test 5, four warps across both dimensions under host stalls
1 30 0003
1 31 0005
1 40 0007
1 41 0009
2 00 03 04 08 3 0 1 0 1 1 00 01 0 0 1 0
3 84 0003 0 0 0 0
3 84 0008 0 1 0 0
3 84 000f 0 2 0 0
3 84 0018 0 3 1 1
4 5
// Test 6, back-to-back commands on one A word
1 50 1000
1 51 0234
2 50 00 05 08 1 0 0 0 2 0 00 00 0 0 0 0
2 51 00 05 08 0 1 1 0 1 0 00 00 0 0 0 0
3 85 1000 0 0 0 0
3 85 2000 1 0 0 0
3 85 2234 0 0 0 1
4 6
0

// ==== sources.f ====
+incdir+logic
logic/tau_cfg_pkg.sv
logic/tau_bus_pkg.sv
logic/nd_offset_counter.sv
logic/awl_index_stage.sv
logic/warp_operand_fetch.sv
logic/accum_update.sv
logic/shared_scratch.sv
logic/accum_looper_top.sv
sim/tb_clock_gen.sv
sim/tb_accum_looper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the accumulation path testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_accum_looper \
	&& ./obj_dir/Vtb_accum_looper | tee sim.log \
	&& grep -qx "No errors" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
